// File: common/armCtrlPkg.sv
package armCtrlPkg;

  // op field, bits 27:26
  localparam logic [1:0] opDp  = 2'b00;
  localparam logic [1:0] opMem = 2'b01;
  localparam logic [1:0] opBr  = 2'b10;

  // dp cmd field, bits 24:21
  localparam logic [3:0] cmdAnd = 4'b0000;
  localparam logic [3:0] cmdSub = 4'b0010;
  localparam logic [3:0] cmdAdd = 4'b0100;
  localparam logic [3:0] cmdOrr = 4'b1100;

  typedef logic [3:0] regAddrT;

  localparam regAddrT pcReg = 4'd15;

  typedef enum logic [3:0] {
    EQ = 4'b0000, NE, CS, CC, MI, PL, VS, VC,
    HI, LS, GE, LT, GT, LE, AL, NV
  } condT;

  typedef enum logic [1:0] {
    ADD = 2'b00,
    SUB = 2'b01,
    AND = 2'b10,
    ORR = 2'b11
  } aluCtrlT;

  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,
    FWD_WB   = 2'b01,
    FWD_MEM  = 2'b10
  } fwdSelT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef struct packed {
    condT        cond;
    logic [1:0]  op;
    logic        imm;
    logic [3:0]  cmd;
    logic        s;
    regAddrT     rn;
    regAddrT     rd;
    logic [11:0] src2;   // rm in [3:0] when imm is clear
  } dpViewT;

  typedef struct packed {
    condT        cond;
    logic [1:0]  op;
    logic        imm;
    logic [3:0]  pubw;   // index/up/byte/writeback, not decoded
    logic        load;
    regAddrT     rn;
    regAddrT     rd;
    logic [11:0] offset;
  } memViewT;

  typedef struct packed {
    condT        cond;
    logic [1:0]  op;
    logic        tag;    // always 1 for b/bl
    logic        link;
    logic [23:0] offset;
  } brViewT;

  typedef union packed {
    dpViewT  dpView;
    memViewT memView;
    brViewT  brView;
  } instrT;

  typedef struct packed {
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;
    logic       memToReg;
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    aluCtrlT    aluControl;
    logic [1:0] flagWrite;
    logic       pcSrc;
  } ctrlD;

  typedef struct packed {
    logic       aluSrc;
    aluCtrlT    aluControl;
    logic       memWrite;
    logic       memToReg;
    logic       regWrite;
    logic       branch;
    logic       pcSrc;
    logic [1:0] flagWrite;
    condT       cond;
  } ctrlE;

  typedef struct packed {
    logic memWrite;
    logic memToReg;
    logic regWrite;
    logic pcSrc;
  } ctrlM;

endpackage

// File: controller/mainDecoder.sv
`timescale 1ns/100ps

module mainDecoder (
  input  armCtrlPkg::instrT   instr,
  output armCtrlPkg::ctrlD    ctrl,
  output armCtrlPkg::regAddrT ra1,
  output armCtrlPkg::regAddrT ra2,
  output armCtrlPkg::regAddrT wa3
);

  import armCtrlPkg::*;

  logic    aluOp;   // dp class, cmd picks the alu op
  regAddrT rnSel;
  regAddrT rmSel;
  regAddrT rdSel;

  always_comb begin
    ctrl  = '0;
    aluOp = 1'b0;
    rnSel = '0;
    rmSel = '0;
    rdSel = '0;
    case (instr.dpView.op)
      opDp: begin
        ctrl.aluSrc   = instr.dpView.imm;
        ctrl.regWrite = 1'b1;
        aluOp         = 1'b1;
        rnSel         = instr.dpView.rn;
        rmSel         = instr.dpView.src2[3:0];
        rdSel         = instr.dpView.rd;
      end
      opMem: begin
        ctrl.regSrc[1] = ~instr.memView.load;   // str reads rd as data
        ctrl.immSrc    = 2'b01;
        ctrl.aluSrc    = 1'b1;
        ctrl.memToReg  = instr.memView.load;
        ctrl.regWrite  = instr.memView.load;
        ctrl.memWrite  = ~instr.memView.load;
        rnSel          = instr.memView.rn;
        rmSel          = instr.memView.offset[3:0];
        rdSel          = instr.memView.rd;
      end
      opBr: begin
        ctrl.regSrc = 2'b01;   // base is the pc
        ctrl.immSrc = 2'b10;
        ctrl.aluSrc = 1'b1;
        ctrl.branch = 1'b1;
      end
      default: ;   // unknown op stays a bubble
    endcase

    if (aluOp) begin
      case (instr.dpView.cmd)
        cmdAdd:  ctrl.aluControl = ADD;
        cmdSub:  ctrl.aluControl = SUB;
        cmdAnd:  ctrl.aluControl = AND;
        cmdOrr:  ctrl.aluControl = ORR;
        default: ctrl.aluControl = ADD;
      endcase
      // nz on any S, cv only for the adder ops
      ctrl.flagWrite[1] = instr.dpView.s;
      ctrl.flagWrite[0] = instr.dpView.s &
                          ((instr.dpView.cmd == cmdAdd) | (instr.dpView.cmd == cmdSub));
    end

    ctrl.pcSrc = ctrl.branch | (ctrl.regWrite & (rdSel == pcReg));
  end

  assign ra1 = ctrl.regSrc[0] ? pcReg : rnSel;
  assign ra2 = ctrl.regSrc[1] ? rdSel : rmSel;
  assign wa3 = rdSel;

endmodule

// File: controller/condUnit.sv
`timescale 1ns/100ps

module condUnit (
  input  logic              clk,
  input  logic              arstN,
  input  armCtrlPkg::condT  cond,
  input  logic [1:0]        flagWrite,
  input  armCtrlPkg::flagsT aluFlags,
  output logic              condEx
);

  import armCtrlPkg::*;

  flagsT flags;
  logic  ge;

  assign ge = (flags.n == flags.v);

  // checked against the stored flags, not this cycle's alu flags
  always_comb begin
    case (cond)
      EQ:      condEx = flags.z;
      NE:      condEx = ~flags.z;
      CS:      condEx = flags.c;
      CC:      condEx = ~flags.c;
      MI:      condEx = flags.n;
      PL:      condEx = ~flags.n;
      VS:      condEx = flags.v;
      VC:      condEx = ~flags.v;
      HI:      condEx = flags.c & ~flags.z;
      LS:      condEx = ~flags.c | flags.z;
      GE:      condEx = ge;
      LT:      condEx = ~ge;
      GT:      condEx = ~flags.z & ge;
      LE:      condEx = flags.z | ~ge;
      AL:      condEx = 1'b1;
      default: condEx = 1'b0;   // nv
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
    end else begin
      if (flagWrite[1] && condEx) begin
        flags.n <= aluFlags.n;
        flags.z <= aluFlags.z;
      end
      if (flagWrite[0] && condEx) begin
        flags.c <= aluFlags.c;
        flags.v <= aluFlags.v;
      end
    end
  end

endmodule

// File: controller/controller.sv
`timescale 1ns/100ps

module controller (
  input  logic                clk,
  input  logic                arstN,
  input  armCtrlPkg::instrT   instrF,
  input  armCtrlPkg::flagsT   aluFlagsE,
  input  logic                stallD,
  input  logic                flushD,
  input  logic                flushE,
  output logic [1:0]          regSrcD,
  output logic [1:0]          immSrcD,
  output logic                aluSrcE,
  output armCtrlPkg::aluCtrlT aluControlE,
  output logic                branchTakenE,
  output logic                memToRegE,
  output logic                memWriteM,
  output logic                regWriteM,
  output logic                memToRegW,
  output logic                regWriteW,
  output logic                pcSrcW,
  output logic                pcWrPendingF,
  output armCtrlPkg::regAddrT ra1D,
  output armCtrlPkg::regAddrT ra2D,
  output armCtrlPkg::regAddrT ra1E,
  output armCtrlPkg::regAddrT ra2E,
  output armCtrlPkg::regAddrT wa3E,
  output armCtrlPkg::regAddrT wa3M,
  output armCtrlPkg::regAddrT wa3W
);

  import armCtrlPkg::*;

  instrT   instrD;
  logic    validD;   // low after reset or flush, D holds a bubble
  ctrlD    decD;
  ctrlD    cwD;
  ctrlE    cwE;
  ctrlM    cwM;
  ctrlM    cwNextM;
  regAddrT wa3D;
  logic    condExE;

  // branch in E overrides the load-use hold
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instrD <= '0;
      validD <= 1'b0;
    end else if (flushD && (!stallD || branchTakenE)) begin
      instrD <= '0;
      validD <= 1'b0;
    end else if (!stallD) begin
      instrD <= instrF;
      validD <= 1'b1;
    end
  end

  mainDecoder mainDecoder_inst (
    .instr (instrD),
    .ctrl  (decD),
    .ra1   (ra1D),
    .ra2   (ra2D),
    .wa3   (wa3D)
  );

  assign cwD = validD ? decD : '0;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cwE  <= '0;
      ra1E <= '0;
      ra2E <= '0;
      wa3E <= '0;
    end else begin
      if (flushE)
        cwE <= '0;
      else
        cwE <= '{aluSrc: cwD.aluSrc, aluControl: cwD.aluControl,
                 memWrite: cwD.memWrite, memToReg: cwD.memToReg,
                 regWrite: cwD.regWrite, branch: cwD.branch, pcSrc: cwD.pcSrc,
                 flagWrite: cwD.flagWrite, cond: instrD.dpView.cond};
      ra1E <= ra1D;
      ra2E <= ra2D;
      wa3E <= wa3D;
    end
  end

  condUnit condUnit_inst (
    .clk       (clk),
    .arstN     (arstN),
    .cond      (cwE.cond),
    .flagWrite (cwE.flagWrite),
    .aluFlags  (aluFlagsE),
    .condEx    (condExE)
  );

  // failed condition kills every architectural write
  assign cwNextM = '{memWrite: cwE.memWrite & condExE, memToReg: cwE.memToReg,
                     regWrite: cwE.regWrite & condExE, pcSrc: cwE.pcSrc & condExE};

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      cwM       <= '0;
      wa3M      <= '0;
      memToRegW <= 1'b0;
      regWriteW <= 1'b0;
      pcSrcW    <= 1'b0;
      wa3W      <= '0;
    end else begin
      cwM       <= cwNextM;
      wa3M      <= wa3E;
      memToRegW <= cwM.memToReg;
      regWriteW <= cwM.regWrite;
      pcSrcW    <= cwM.pcSrc;
      wa3W      <= wa3M;
    end
  end

  assign regSrcD      = cwD.regSrc;
  assign immSrcD      = cwD.immSrc;
  assign aluSrcE      = cwE.aluSrc;
  assign aluControlE  = cwE.aluControl;
  assign memToRegE    = cwE.memToReg;
  assign branchTakenE = cwE.branch & condExE;
  assign memWriteM    = cwM.memWrite;
  assign regWriteM    = cwM.regWrite;
  assign pcWrPendingF = cwD.pcSrc | cwE.pcSrc | cwM.pcSrc;   // E is ungated here

endmodule

// File: rtl/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
  input  armCtrlPkg::regAddrT ra1D,
  input  armCtrlPkg::regAddrT ra2D,
  input  armCtrlPkg::regAddrT ra1E,
  input  armCtrlPkg::regAddrT ra2E,
  input  armCtrlPkg::regAddrT wa3E,
  input  armCtrlPkg::regAddrT wa3M,
  input  armCtrlPkg::regAddrT wa3W,
  input  logic                memToRegE,
  input  logic                regWriteM,
  input  logic                regWriteW,
  input  logic                pcSrcW,
  input  logic                branchTakenE,
  input  logic                pcWrPendingF,
  output armCtrlPkg::fwdSelT  forwardAE,
  output armCtrlPkg::fwdSelT  forwardBE,
  output logic                stallF,
  output logic                stallD,
  output logic                flushD,
  output logic                flushE
);

  import armCtrlPkg::*;

  logic ldrStall;

  // youngest producer wins, M before W
  function automatic fwdSelT pickFwd(
    input regAddrT ra,
    input logic    wrM,
    input regAddrT waM,
    input logic    wrW,
    input regAddrT waW
  );
    fwdSelT sel;
    if (wrM && (waM == ra))
      sel = FWD_MEM;
    else if (wrW && (waW == ra))
      sel = FWD_WB;
    else
      sel = FWD_NONE;
    return sel;
  endfunction

  assign forwardAE = pickFwd(ra1E, regWriteM, wa3M, regWriteW, wa3W);
  assign forwardBE = pickFwd(ra2E, regWriteM, wa3M, regWriteW, wa3W);

  // ldr result not ready until M, hold D one cycle
  assign ldrStall = memToRegE & ((wa3E == ra1D) | (wa3E == ra2D));

  assign stallD = ldrStall;
  assign stallF = ldrStall | pcWrPendingF;   // fetch waits for the new pc

  assign flushD = pcWrPendingF | pcSrcW | branchTakenE;
  assign flushE = ldrStall | branchTakenE;

endmodule

// File: rtl/armControlTop.sv
`timescale 1ns/100ps

module armControlTop (
  input  logic                clk,
  input  logic                arstN,
  input  armCtrlPkg::instrT   instrF,
  input  armCtrlPkg::flagsT   aluFlagsE,
  output logic [1:0]          regSrcD,
  output logic [1:0]          immSrcD,
  output logic                aluSrcE,
  output armCtrlPkg::aluCtrlT aluControlE,
  output logic                branchTakenE,
  output logic                memToRegE,
  output logic                memWriteM,
  output logic                regWriteM,
  output logic                memToRegW,
  output logic                regWriteW,
  output logic                pcSrcW,
  output logic                pcWrPendingF,
  output armCtrlPkg::fwdSelT  forwardAE,
  output armCtrlPkg::fwdSelT  forwardBE,
  output logic                stallF,
  output logic                stallD,
  output logic                flushD,
  output logic                flushE
);

  import armCtrlPkg::*;

  // register numbers passed to the hazard unit
  regAddrT ra1D;
  regAddrT ra2D;
  regAddrT ra1E;
  regAddrT ra2E;
  regAddrT wa3E;
  regAddrT wa3M;
  regAddrT wa3W;

  controller controller_inst (
    .clk          (clk),
    .arstN        (arstN),
    .instrF       (instrF),
    .aluFlagsE    (aluFlagsE),
    .stallD       (stallD),
    .flushD       (flushD),
    .flushE       (flushE),
    .regSrcD      (regSrcD),
    .immSrcD      (immSrcD),
    .aluSrcE      (aluSrcE),
    .aluControlE  (aluControlE),
    .branchTakenE (branchTakenE),
    .memToRegE    (memToRegE),
    .memWriteM    (memWriteM),
    .regWriteM    (regWriteM),
    .memToRegW    (memToRegW),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .pcWrPendingF (pcWrPendingF),
    .ra1D         (ra1D),
    .ra2D         (ra2D),
    .ra1E         (ra1E),
    .ra2E         (ra2E),
    .wa3E         (wa3E),
    .wa3M         (wa3M),
    .wa3W         (wa3W)
  );

  hazardUnit hazardUnit_inst (
    .ra1D         (ra1D),
    .ra2D         (ra2D),
    .ra1E         (ra1E),
    .ra2E         (ra2E),
    .wa3E         (wa3E),
    .wa3M         (wa3M),
    .wa3W         (wa3W),
    .memToRegE    (memToRegE),
    .regWriteM    (regWriteM),
    .regWriteW    (regWriteW),
    .pcSrcW       (pcSrcW),
    .branchTakenE (branchTakenE),
    .pcWrPendingF (pcWrPendingF),
    .forwardAE    (forwardAE),
    .forwardBE    (forwardBE),
    .stallF       (stallF),
    .stallD       (stallD),
    .flushD       (flushD),
    .flushE       (flushE)
  );

endmodule

// File: bench/armControl_assertions.sv
`timescale 1ns/100ps

module armControl_assertions (
  input logic               clk,
  input logic               arstN,
  input logic               stallF,
  input logic               stallD,
  input logic               flushD,
  input logic               flushE,
  input logic               branchTakenE,
  input logic               regWriteM,
  input armCtrlPkg::fwdSelT forwardAE
);

  import armCtrlPkg::*;

  int unsigned failCount = 0;

  stallDImpliesStallF: assert property (@(posedge clk) disable iff (!arstN)
      stallD |-> stallF)
    else begin
      failCount++;
      $error("stallD high while stallF low");
    end

  // taken branch squashes both D and E
  branchFlushesD: assert property (@(posedge clk) disable iff (!arstN)
      (flushE && branchTakenE) |-> flushD)
    else begin
      failCount++;
      $error("taken branch flushed E but not D");
    end

  fwdMemNeedsWrite: assert property (@(posedge clk) disable iff (!arstN)
      (forwardAE == FWD_MEM) |-> regWriteM)
    else begin
      failCount++;
      $error("forwardAE selects M with no register write in M");
    end

endmodule

// File: bench/ctrlChecker.sv
`timescale 1ns/100ps

module ctrlChecker (
  input logic                clk,
  input logic                arstN,
  input armCtrlPkg::instrT   instrF,
  input armCtrlPkg::flagsT   aluFlagsE,
  input logic [1:0]          regSrcD,
  input logic [1:0]          immSrcD,
  input logic                aluSrcE,
  input armCtrlPkg::aluCtrlT aluControlE,
  input logic                branchTakenE,
  input logic                memToRegE,
  input logic                memWriteM,
  input logic                regWriteM,
  input logic                memToRegW,
  input logic                regWriteW,
  input logic                pcSrcW,
  input logic                pcWrPendingF,
  input armCtrlPkg::fwdSelT  forwardAE,
  input armCtrlPkg::fwdSelT  forwardBE,
  input logic                stallF,
  input logic                stallD,
  input logic                flushD,
  input logic                flushE
);

  import armCtrlPkg::*;

  int unsigned errors = 0;
  int unsigned checks = 0;

  // shadow pipeline state
  logic [31:0] instrDSh;
  logic        validDSh;
  ctrlE        cwESh;
  ctrlM        cwMSh;
  ctrlM        cwWSh;   // memWrite unused in W
  regAddrT     ra1ESh;
  regAddrT     ra2ESh;
  regAddrT     wa3ESh;
  regAddrT     wa3MSh;
  regAddrT     wa3WSh;
  flagsT       flagsSh;

  function automatic void decodeRef(
    input  logic [31:0] w,
    output ctrlD        c,
    output regAddrT     a1,
    output regAddrT     a2,
    output regAddrT     a3
  );
    logic [3:0] cmd;
    logic       addSub;
    cmd    = w[24:21];
    addSub = (cmd == 4'b0100) || (cmd == 4'b0010);
    c      = '0;
    a1     = '0;
    a2     = '0;
    a3     = '0;
    case (w[27:26])
      2'b00: begin
        c.aluSrc   = w[25];
        c.regWrite = 1'b1;
        case (cmd)
          4'b0010: c.aluControl = SUB;
          4'b0000: c.aluControl = AND;
          4'b1100: c.aluControl = ORR;
          default: c.aluControl = ADD;
        endcase
        c.flagWrite = {w[20], w[20] & addSub};
        a1 = w[19:16];
        a2 = w[3:0];
        a3 = w[15:12];
      end
      2'b01: begin
        c.regSrc   = {~w[20], 1'b0};   // store data comes from rd
        c.immSrc   = 2'b01;
        c.aluSrc   = 1'b1;
        c.memToReg = w[20];
        c.regWrite = w[20];
        c.memWrite = ~w[20];
        a1 = w[19:16];
        a2 = w[20] ? w[3:0] : w[15:12];
        a3 = w[15:12];
      end
      2'b10: begin
        c.regSrc = 2'b01;
        c.immSrc = 2'b10;
        c.aluSrc = 1'b1;
        c.branch = 1'b1;
        a1 = 4'd15;
      end
      default: ;
    endcase
    c.pcSrc = c.branch | (c.regWrite & (a3 == 4'd15));
  endfunction

  // odd codes negate the even code below them
  function automatic logic condRef(input logic [3:0] cond, input flagsT f);
    logic r;
    case (cond[3:1])
      3'd0:    r = f.z;
      3'd1:    r = f.c;
      3'd2:    r = f.n;
      3'd3:    r = f.v;
      3'd4:    r = f.c & ~f.z;
      3'd5:    r = (f.n == f.v);
      3'd6:    r = ~f.z & (f.n == f.v);
      default: r = 1'b1;
    endcase
    return cond[0] ? ~r : r;
  endfunction

  // {fwdA, fwdB, stallF, stallD, flushD, flushE}
  function automatic logic [7:0] hazardRef(
    input regAddrT a1D,
    input regAddrT a2D,
    input regAddrT a1E,
    input regAddrT a2E,
    input regAddrT w3E,
    input regAddrT w3M,
    input regAddrT w3W,
    input logic    ldE,
    input logic    wrM,
    input logic    wrW,
    input logic    pcW,
    input logic    brTaken,
    input logic    pcPend
  );
    logic [1:0] fa;
    logic [1:0] fb;
    logic       ldStall;
    fa = (wrM && w3M == a1E) ? FWD_MEM : (wrW && w3W == a1E) ? FWD_WB : FWD_NONE;
    fb = (wrM && w3M == a2E) ? FWD_MEM : (wrW && w3W == a2E) ? FWD_WB : FWD_NONE;
    ldStall = ldE && (w3E == a1D || w3E == a2D);
    return {fa, fb, ldStall | pcPend, ldStall, pcPend | pcW | brTaken, ldStall | brTaken};
  endfunction

  task automatic checkSig(input string name, input logic [3:0] got, input logic [3:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic resetModel();
    instrDSh = '0;
    validDSh = 1'b0;
    cwESh    = '0;
    cwMSh    = '0;
    cwWSh    = '0;
    ra1ESh   = '0;
    ra2ESh   = '0;
    wa3ESh   = '0;
    wa3MSh   = '0;
    wa3WSh   = '0;
    flagsSh  = '0;
  endtask

  // outputs are settled at the falling edge, inputs stay until the next rise
  always @(negedge clk) begin : compare
    ctrlD       cwD;
    regAddrT    a1D;
    regAddrT    a2D;
    regAddrT    a3D;
    logic       condEx;
    logic       brTaken;
    logic       pcPend;
    logic [1:0] fwdA;
    logic [1:0] fwdB;
    logic       stF;
    logic       stD;
    logic       flD;
    logic       flE;
    logic [3:0] wrMask;
    if (!arstN)
      resetModel();
    decodeRef(instrDSh, cwD, a1D, a2D, a3D);
    if (!validDSh)
      cwD = '0;
    condEx  = condRef(cwESh.cond, flagsSh);
    brTaken = cwESh.branch & condEx;
    pcPend  = cwD.pcSrc | cwESh.pcSrc | cwMSh.pcSrc;
    {fwdA, fwdB, stF, stD, flD, flE} = hazardRef(a1D, a2D, ra1ESh, ra2ESh, wa3ESh, wa3MSh,
        wa3WSh, cwESh.memToReg, cwMSh.regWrite, cwWSh.regWrite, cwWSh.pcSrc, brTaken, pcPend);

    checkSig("regSrcD", regSrcD, cwD.regSrc);
    checkSig("immSrcD", immSrcD, cwD.immSrc);
    checkSig("aluSrcE", aluSrcE, cwESh.aluSrc);
    checkSig("aluControlE", aluControlE, cwESh.aluControl);
    checkSig("branchTakenE", branchTakenE, brTaken);
    checkSig("memToRegE", memToRegE, cwESh.memToReg);
    checkSig("memWriteM", memWriteM, cwMSh.memWrite);
    checkSig("regWriteM", regWriteM, cwMSh.regWrite);
    checkSig("memToRegW", memToRegW, cwWSh.memToReg);
    checkSig("regWriteW", regWriteW, cwWSh.regWrite);
    checkSig("pcSrcW", pcSrcW, cwWSh.pcSrc);
    checkSig("pcWrPendingF", pcWrPendingF, pcPend);
    checkSig("forwardAE", forwardAE, fwdA);
    checkSig("forwardBE", forwardBE, fwdB);
    checkSig("stallF", stallF, stF);
    checkSig("stallD", stallD, stD);
    checkSig("flushD", flushD, flD);
    checkSig("flushE", flushE, flE);

    if (arstN) begin
      // oldest stage first so each reads the previous state
      cwWSh  = cwMSh;
      wa3WSh = wa3MSh;
      cwMSh  = '{memWrite: cwESh.memWrite & condEx, memToReg: cwESh.memToReg,
                 regWrite: cwESh.regWrite & condEx, pcSrc: cwESh.pcSrc & condEx};
      wa3MSh = wa3ESh;
      wrMask  = {{2{cwESh.flagWrite[1] & condEx}}, {2{cwESh.flagWrite[0] & condEx}}};
      flagsSh = (aluFlagsE & wrMask) | (flagsSh & ~wrMask);
      if (flE)
        cwESh = '0;
      else
        cwESh = '{aluSrc: cwD.aluSrc, aluControl: cwD.aluControl, memWrite: cwD.memWrite,
                  memToReg: cwD.memToReg, regWrite: cwD.regWrite, branch: cwD.branch,
                  pcSrc: cwD.pcSrc, flagWrite: cwD.flagWrite, cond: condT'(instrDSh[31:28])};
      ra1ESh = a1D;
      ra2ESh = a2D;
      wa3ESh = a3D;
      if (flD && (!stD || brTaken)) begin
        instrDSh = '0;
        validDSh = 1'b0;
      end else if (!stD) begin
        instrDSh = instrF;
        validDSh = 1'b1;
      end
    end
  end

endmodule

// File: bench/armControlTb.sv
`timescale 1ns/100ps

module armControlTb;

  import armCtrlPkg::*;

  localparam int resetCycles  = 16;
  localparam int stimCycles   = 1000;
  localparam int drainCycles  = 8;
  localparam int marginCycles = 176;
  localparam int cycleLimit   = resetCycles + stimCycles + drainCycles + marginCycles;

  logic    clk = 1'b0;
  logic    arstN;
  instrT   instrF;
  flagsT   aluFlagsE;
  logic [1:0] regSrcD;
  logic [1:0] immSrcD;
  logic    aluSrcE;
  aluCtrlT aluControlE;
  logic    branchTakenE;
  logic    memToRegE;
  logic    memWriteM;
  logic    regWriteM;
  logic    memToRegW;
  logic    regWriteW;
  logic    pcSrcW;
  logic    pcWrPendingF;
  fwdSelT  forwardAE;
  fwdSelT  forwardBE;
  logic    stallF;
  logic    stallD;
  logic    flushD;
  logic    flushE;
  int      cycleCount = 0;
  int      assertFails;

  always #20 clk = ~clk;

  armControlTop armControlTop_inst (.*);

  ctrlChecker ctrlChecker_inst (.*);

  bind armControlTop armControl_assertions armControl_assertions_inst (.*);

  // mostly r0..r3 so hazards are frequent, r15 now and then
  function automatic regAddrT pickReg();
    regAddrT r;
    if ($urandom % 32 == 0)
      r = pcReg;
    else
      r = 4'($urandom % 4);
    return r;
  endfunction

  function automatic logic [31:0] makeInstr();
    int unsigned kind;
    logic [3:0]  cond;
    logic [3:0]  cmd;
    logic [31:0] w;
    kind = $urandom % 100;
    cond = ($urandom % 2) ? 4'hE : 4'($urandom);   // half of them always
    case ($urandom % 4)
      0:       cmd = 4'b0000;
      1:       cmd = 4'b0010;
      2:       cmd = 4'b0100;
      default: cmd = 4'b1100;
    endcase
    if (kind < 60)
      w = {cond, 2'b00, 1'($urandom), cmd, 1'($urandom), pickReg(), pickReg(),
           8'($urandom), pickReg()};
    else if (kind < 90)
      w = {cond, 2'b01, 1'($urandom), 4'b1100, 1'($urandom), pickReg(), pickReg(),
           8'($urandom), pickReg()};
    else
      w = {cond, 2'b10, 1'b1, 1'($urandom), 24'($urandom)};
    return w;
  endfunction

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h86eb));
    arstN     = 1'b0;
    instrF    = '0;
    aluFlagsE = '0;
    repeat (resetCycles) @(posedge clk);
    arstN <= 1'b1;
    repeat (stimCycles) begin
      @(posedge clk);
      if (!stallF)
        instrF <= makeInstr();   // fetch holds while stalled
      aluFlagsE <= 4'($urandom);
    end
    repeat (drainCycles) @(posedge clk);
    assertFails = armControlTop_inst.armControl_assertions_inst.failCount;
    $display("summary: %0d checks, %0d mismatches, %0d assertion failures",
             ctrlChecker_inst.checks, ctrlChecker_inst.errors, assertFails);
    if (ctrlChecker_inst.errors == 0 && assertFails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: list.f
common/armCtrlPkg.sv
controller/mainDecoder.sv
controller/condUnit.sv
controller/controller.sv
rtl/hazardUnit.sv
rtl/armControlTop.sv
bench/armControl_assertions.sv
bench/ctrlChecker.sv
bench/armControlTb.sv
